// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - verilog/spi_pkg.sv
  - verilog/spi_word_if.sv
  - verilog/spi_host_port.sv
  - verilog/spi_sck_timer.sv
  - verilog/spi_shift_engine.sv
  - verilog/spi_master.sv
  - target: test
    files:
      - test/spi_slave_model.sv
      - test/tb_spi_master.sv

// ==== spi_master.f ====
verilog/spi_pkg.sv
verilog/spi_word_if.sv
verilog/spi_host_port.sv
verilog/spi_sck_timer.sv
verilog/spi_shift_engine.sv
verilog/spi_master.sv
test/spi_slave_model.sv
test/tb_spi_master.sv

// ==== test/spi_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// Behavioral SPI slave. Mode and bit order come from the testbench.
module spi_slave_model (
    input  logic           sck,
    input  logic           mosi,
    input  logic           ss,
    output logic           miso,
    input  logic [1:0]     mode,       // Bit 1 polarity, bit 0 phase.
    input  logic           lsb_first,
    input  spi_pkg::word_t reply,      // Word returned in the next frame.
    output spi_pkg::word_t captured,   // Last word seen on mosi.
    output int             frames      // Completed frames.
);
    import spi_pkg::*;

    word_t out_sh;   // Reply bits still to drive, next at MSB.
    word_t in_sh;    // Bits sampled so far, newest at LSB.
    int    edges;    // sck edges in this frame.
    logic  leading;  // Edge moved sck away from the idle level.

    // Wire order to word order and back.
    function automatic word_t mirror(input word_t w);
        word_t r;
        for (int i = 0; i < word_len; i++) begin
            r[i] = w[word_len-1-i];
        end
        return r;
    endfunction

    // Phase 0 needs the first bit before the first edge.
    task automatic start_frame();
        edges  = 0;
        out_sh = lsb_first ? mirror(reply) : reply;
        if (!mode[0]) begin
            miso   = out_sh[word_len-1];
            out_sh = out_sh << 1;
        end
    endtask

    initial begin
        miso     = 1'b1;
        captured = '0;
        frames   = 0;
        edges    = 0;
        in_sh    = '0;
        out_sh   = '0;
    end

    always @(negedge ss) start_frame();  // Fresh select.

    always @(posedge sck or negedge sck) begin
        leading = (sck != mode[1]);
        // Edges alternate starting with a leading one; a polarity change at select is skipped.
        if (ss === 1'b0 && leading == !edges[0]) begin
            edges = edges + 1;
            if (leading != mode[0]) begin
                in_sh = {in_sh[word_len-2:0], mosi};  // Sampling edge.
            end else begin
                miso   = out_sh[word_len-1];          // Launching edge.
                out_sh = out_sh << 1;
            end
            if (edges == 2*word_len) begin
                captured = lsb_first ? mirror(in_sh) : in_sh;
                frames   = frames + 1;
                start_frame();                         // ss may stay low.
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master;
    import spi_pkg::*;

    localparam int seed    = 32052;
    localparam int n_words = 13;    // 8 single, 3 back to back, 2 overwrite.
    localparam int margin  = 64;    // Handshake cycles per word.

    logic       wr = 1'b0;
    logic       rst;
    logic       tx_req;
    logic       tx_ack;
    word_t      tx_data;
    logic       tx_lsb_first;
    spi_mode_e  tx_mode;
    presc_t     tx_presc;
    logic       rx_valid;
    logic       rx_ack;
    word_t      rx_data;
    logic       sck;
    logic       mosi;
    logic       ss;
    logic       miso;
    logic [1:0] slave_mode;
    logic       slave_lsb;
    word_t      slave_reply;
    word_t      slave_word;
    int         slave_frames;
    word_t      w_data  [n_words];  // Stimulus, drawn before reset.
    word_t      w_reply [n_words];
    presc_t     w_presc [n_words];
    logic [1:0] w_mode  [n_words];
    logic       w_lsb   [n_words];
    int         errors, tests, passed, cycles, limit;
    int         sck_pulses, words_acked, gate_frames;
    logic       idle_pol;           // Polarity of the last started frame.
    logic       ack_gate;           // Third word must wait for a take.
    logic       ss_hold;            // Frames are chained.

    always #10 wr = ~wr;            // 20 ns period.

    spi_master u_dut (
        .wr(wr), .rst(rst), .tx_req(tx_req), .tx_ack(tx_ack), .tx_data(tx_data),
        .tx_lsb_first(tx_lsb_first), .tx_mode(tx_mode), .tx_presc(tx_presc),
        .rx_valid(rx_valid), .rx_ack(rx_ack), .rx_data(rx_data),
        .sck(sck), .mosi(mosi), .ss(ss), .miso(miso)
    );

    spi_slave_model u_slave (
        .sck(sck), .mosi(mosi), .ss(ss), .miso(miso), .mode(slave_mode),
        .lsb_first(slave_lsb), .reply(slave_reply), .captured(slave_word),
        .frames(slave_frames)
    );

    ////////////////////
    // Monitors
    ////////////////////

    always @(posedge sck or negedge sck) begin
        if (ss === 1'b0 && sck !== slave_mode[1]) sck_pulses++;  // Leading edges only.
    end

    always @(posedge tx_ack) words_acked++;
    always @(negedge ss) idle_pol = slave_mode[1];

    always @(posedge wr) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_reset: assert property (@(posedge wr) $fell(rst) |-> ss && mosi && !tx_ack && !rx_valid)
        else begin
            errors++;
            $display("ERROR: reset ss/mosi/tx_ack/rx_valid expected 1/1/0/0 got %h/%h/%h/%h",
                     ss, mosi, tx_ack, rx_valid);
        end

    a_tx_word: assert property (@(posedge wr) disable iff (rst)
        $changed(slave_frames) |-> slave_word == w_data[slave_frames-1])
        else begin
            errors++;
            $display("ERROR: slave_word expected %h got %h",
                     w_data[slave_frames-1], slave_word);
        end

    a_rx_word: assert property (@(posedge wr) disable iff (rst)
        $changed(slave_frames) |=> rx_valid && rx_data == w_reply[slave_frames-1])
        else begin
            errors++;
            $display("ERROR: rx_data expected %h got %h, rx_valid %h",
                     w_reply[slave_frames-1], rx_data, rx_valid);
        end

    a_sck_idle: assert property (@(posedge wr) disable iff (rst) ss |-> sck == idle_pol)
        else begin
            errors++;
            $display("ERROR: sck expected %h got %h", idle_pol, sck);
        end

    a_pulses: assert property (@(posedge wr) disable iff (rst)
        $rose(ss) |-> sck_pulses == word_len * words_acked)
        else begin
            errors++;
            $display("ERROR: sck_pulses expected %h got %h",
                     word_len * words_acked, sck_pulses);
        end

    a_ss_chain: assert property (@(posedge wr) disable iff (rst) ss_hold |-> !ss)
        else begin
            errors++;
            $display("ERROR: ss expected 0 got %h", ss);
        end

    a_ack_wait: assert property (@(posedge wr) disable iff (rst)
        ack_gate && slave_frames == gate_frames |-> !tx_ack)
        else begin
            errors++;
            $display("ERROR: tx_ack expected 0 got %h", tx_ack);
        end

    // The DUT decides on the edge before tx_ack shows high.
    a_ack_rise: assert property (@(posedge wr) disable iff (rst) $rose(tx_ack) |-> $past(tx_req))
        else begin
            errors++;
            $display("tx_ack rose while tx_req was low");
        end

    a_ack_fall: assert property (@(posedge wr) disable iff (rst) $fell(tx_ack) |-> !$past(tx_req))
        else begin
            errors++;
            $display("tx_ack fell before tx_req was dropped");
        end

    a_rx_release: assert property (@(posedge wr) disable iff (rst) $fell(rx_valid) |-> $past(rx_ack))
        else begin
            errors++;
            $display("rx_valid fell without rx_ack from the host");
        end

    ////////////////////
    // Host side
    ////////////////////

    task automatic send_word(input int i);
        @(negedge wr);
        tx_data      = w_data[i];
        tx_lsb_first = w_lsb[i];
        tx_mode      = spi_mode_e'(w_mode[i]);
        tx_presc     = w_presc[i];
        tx_req       = 1'b1;
        @(negedge wr);
        while (!tx_ack) @(negedge wr);
        tx_req = 1'b0;                      // Close the four-phase cycle.
        while (tx_ack) @(negedge wr);
    endtask

    task automatic take_reply();
        while (!rx_valid) @(negedge wr);
        rx_ack = 1'b1;
        @(negedge wr);
        while (rx_valid) @(negedge wr);
        rx_ack = 1'b0;
        @(negedge wr);
    endtask

    task automatic load_slave(input int i);
        slave_mode  = w_mode[i];
        slave_lsb   = w_lsb[i];
        slave_reply = w_reply[i];
    endtask

    task automatic wait_frames(input int n);
        while (slave_frames < n) @(negedge wr);
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            passed++;
            $display("test %-14s pass", name);
        end else begin
            $display("test %-14s fail, %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int i;
        int mark;
        int first;
        void'($urandom(seed));
        {tx_req, tx_data, tx_lsb_first, tx_presc, rx_ack} = '0;
        tx_mode = mode_0;
        rst     = 1'b1;
        {slave_mode, slave_lsb, slave_reply} = '0;
        errors      = 0;
        tests       = 0;
        passed      = 0;
        cycles      = 0;
        sck_pulses  = 0;
        words_acked = 0;
        gate_frames = 0;
        {idle_pol, ack_gate, ss_hold} = '0;
        limit = 16 + 200;                   // Reset and tail.
        for (i = 0; i < n_words; i++) begin
            w_data[i]  = word_t'($urandom());
            w_reply[i] = word_t'($urandom());
            w_presc[i] = presc_t'($urandom_range(7, 0));
            w_mode[i]  = (i < 8) ? 2'(i % 4) : 2'($urandom_range(3, 0));
            w_lsb[i]   = (i < 8) ? (i >= 4) : 1'($urandom_range(1, 0));
            limit += 2 * 16 * (2 << w_presc[i]) + margin;  // Twice the frame length.
        end
        w_mode[9]  = w_mode[8];             // One mode for the chained frames.
        w_mode[10] = w_mode[8];
        w_lsb[9]   = w_lsb[8];
        w_lsb[10]  = w_lsb[8];

        repeat (8) @(posedge wr);
        @(negedge wr);
        rst  = 1'b0;
        mark = errors;
        repeat (3) @(negedge wr);
        report("reset_state", mark);

        // All modes, MSB first then LSB first.
        for (i = 0; i < 8; i++) begin
            mark = errors;
            load_slave(i);
            send_word(i);
            take_reply();
            repeat (2) @(negedge wr);
            report($sformatf("mode%0d_%s", w_mode[i], w_lsb[i] ? "lsb" : "msb"), mark);
        end

        // Three chained words, the third meets a full buffer.
        mark  = errors;
        first = slave_frames;
        load_slave(8);
        send_word(8);
        while (ss) @(negedge wr);
        ss_hold     = 1'b1;
        slave_reply = w_reply[9];
        send_word(9);
        gate_frames = slave_frames;
        ack_gate    = 1'b1;
        send_word(10);
        ack_gate    = 1'b0;
        slave_reply = w_reply[10];
        wait_frames(first + 3);
        ss_hold = 1'b0;
        take_reply();
        report("back_to_back", mark);

        // Second frame lands while rx_valid is still high.
        mark  = errors;
        first = slave_frames;
        load_slave(11);
        send_word(11);
        wait_frames(first + 1);
        while (!ss) @(negedge wr);
        load_slave(12);
        send_word(12);
        wait_frames(first + 2);
        while (!ss) @(negedge wr);
        take_reply();
        report("rx_overwrite", mark);

        repeat (4) @(negedge wr);
        $display("tests %0d, passed %0d, errors %0d", tests, passed, errors);
        if (errors == 0 && passed == tests) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/spi_host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_host_port (
    input  logic               wr,
    input  logic               rst,
    input  logic               tx_req,
    output logic               tx_ack,
    input  spi_pkg::word_t     tx_data,
    input  logic               tx_lsb_first,
    input  spi_pkg::spi_mode_e tx_mode,
    input  spi_pkg::presc_t    tx_presc,
    output logic               rx_valid,
    input  logic               rx_ack,
    output spi_pkg::word_t     rx_data,
    spi_word_if.port           word
);

    logic tx_load;      // Accept the host word into the buffer.
    logic rx_release;   // Host acknowledged the received word.
    logic rx_ack_hold;  // Wait for rx_ack low before the next release.

    ////////////////////
    // Transmit side
    ////////////////////

    // Request seen, ack not yet given, buffer empty.
    assign tx_load = tx_req && !tx_ack && !word.tx_valid;

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            tx_ack        <= 1'b0;
            word.tx_valid <= 1'b0;
        end else begin
            if (tx_load) begin
                tx_ack <= 1'b1;                // Word is in the buffer.
            end else if (!tx_req) begin
                tx_ack <= 1'b0;                // Host dropped req, close the cycle.
            end
            if (word.tx_taken) begin
                word.tx_valid <= 1'b0;         // Engine has its copy now.
            end else if (tx_load) begin
                word.tx_valid <= 1'b1;
            end
        end
    end

    // Holding buffer, written only when empty.
    always_ff @(posedge wr) begin
        if (tx_load) begin
            word.tx_word      <= tx_data;
            word.tx_lsb_first <= tx_lsb_first;
            word.tx_mode      <= tx_mode;
            word.tx_presc     <= tx_presc;
        end
    end

    ////////////////////
    // Receive side
    ////////////////////

    // A new frame result wins over a pending release.
    assign rx_release = rx_valid && rx_ack && !rx_ack_hold;

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            rx_valid    <= 1'b0;
            rx_ack_hold <= 1'b0;
        end else begin
            if (word.rx_done) begin
                rx_valid <= 1'b1;              // Stays high on overwrite.
            end else if (rx_release) begin
                rx_valid <= 1'b0;
            end
            if (rx_release && !word.rx_done) begin
                rx_ack_hold <= 1'b1;           // Host still holds rx_ack.
            end else if (!rx_ack) begin
                rx_ack_hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge wr) begin
        if (word.rx_done) begin
            rx_data <= word.rx_word;           // Newest frame always lands here.
        end
    end

    // Acknowledge only answers a raised request.
    a_ack_after_req: assert property (@(posedge wr) disable iff (rst)
        $rose(tx_ack) |-> $past(tx_req));

    // Host must have acknowledged before the word goes away.
    a_valid_fall: assert property (@(posedge wr) disable iff (rst)
        $fell(rx_valid) |-> $past(rx_ack));

endmodule

`default_nettype wire

// ==== verilog/spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_master (
    input  logic               wr,
    input  logic               rst,
    // Host transmit handshake.
    input  logic               tx_req,
    output logic               tx_ack,
    input  spi_pkg::word_t     tx_data,
    input  logic               tx_lsb_first,
    input  spi_pkg::spi_mode_e tx_mode,
    input  spi_pkg::presc_t    tx_presc,
    // Host receive handshake.
    output logic               rx_valid,
    input  logic               rx_ack,
    output spi_pkg::word_t     rx_data,
    // SPI lines.
    output logic               sck,
    output logic               mosi,
    output logic               ss,
    input  logic               miso
);
    import spi_pkg::*;

    logic   run;        // Engine is inside a frame.
    presc_t presc;      // Latched divider for this frame.
    logic   half_tick;  // End of an SPI half period.

    spi_word_if word_if ();

    ////////////////////
    // Blocks
    ////////////////////

    spi_host_port u_host_port (
        .wr           (wr),
        .rst          (rst),
        .tx_req       (tx_req),
        .tx_ack       (tx_ack),
        .tx_data      (tx_data),
        .tx_lsb_first (tx_lsb_first),
        .tx_mode      (tx_mode),
        .tx_presc     (tx_presc),
        .rx_valid     (rx_valid),
        .rx_ack       (rx_ack),
        .rx_data      (rx_data),
        .word         (word_if)
    );

    spi_sck_timer u_sck_timer (
        .wr        (wr),
        .rst       (rst),
        .run       (run),
        .presc     (presc),
        .half_tick (half_tick)
    );

    spi_shift_engine u_shift_engine (
        .wr        (wr),
        .rst       (rst),
        .word      (word_if),
        .run       (run),
        .presc     (presc),
        .half_tick (half_tick),
        .miso      (miso),
        .sck       (sck),
        .mosi      (mosi),
        .ss        (ss)
    );

endmodule

`default_nettype wire

// ==== verilog/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int word_len  = 8;  // Bits per SPI word.
    localparam int presc_len = 3;  // Width of the prescaler select.
    localparam int cnt_len   = 9;  // Half-period counter, reaches 256.

    ////////////////////
    // Types
    ////////////////////

    typedef logic [word_len-1:0]  word_t;   // One data word.
    typedef logic [presc_len-1:0] presc_t;  // Divider is 2^(presc+1) per half period.

    // Bit 1 is clock polarity, bit 0 is clock phase.
    typedef enum logic [1:0] {
        mode_0 = 2'b00,  // Idle low, sample on leading edge.
        mode_1 = 2'b01,  // Idle low, sample on trailing edge.
        mode_2 = 2'b10,  // Idle high, sample on leading edge.
        mode_3 = 2'b11   // Idle high, sample on trailing edge.
    } spi_mode_e;

    // Frame sequencer of the shift engine.
    typedef enum logic [1:0] {
        idle = 2'b00,  // Waiting for a word.
        run  = 2'b01,  // Frame in progress.
        done = 2'b10   // Last half period seen, result ready.
    } engine_state_e;

endpackage

`default_nettype wire

// ==== verilog/spi_sck_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_sck_timer (
    input  logic            wr,
    input  logic            rst,
    input  logic            run,
    input  spi_pkg::presc_t presc,
    output logic            half_tick
);
    import spi_pkg::*;

    logic [cnt_len-1:0] cnt;   // Cycles elapsed in this half period.
    logic [cnt_len-1:0] term;  // Last count of a half period.

    ////////////////////
    // Terminal count
    ////////////////////

    // Half period is 2^(presc+1) cycles of wr.
    // presc 0 gives 1, presc 7 gives 255.
    assign term = (cnt_len'(2) << presc) - 1'b1;

    ////////////////////
    // Counter
    ////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;                   // Hold at zero between frames.
        end else if (cnt == term) begin
            cnt <= '0;                   // Wrap at the half-period boundary.
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // The engine acts on the edge that ends this cycle.
    // term is never zero, so a cleared counter keeps this low.
    assign half_tick = (cnt == term);

    // Counter clear must keep the tick quiet outside a frame.
    a_no_tick_idle: assert property (@(posedge wr) disable iff (rst)
        !run |-> !half_tick);

endmodule

`default_nettype wire

// ==== verilog/spi_shift_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine (
    input  logic            wr,
    input  logic            rst,
    spi_word_if.engine      word,
    output logic            run,
    output spi_pkg::presc_t presc,
    input  logic            half_tick,
    input  logic            miso,
    output logic            sck,
    output logic            mosi,
    output logic            ss
);
    import spi_pkg::*;

    typedef logic [$clog2(2*word_len)-1:0] half_cnt_t;

    engine_state_e state;
    half_cnt_t     hcnt;        // Half periods done in this frame.
    logic          sck_ph;      // Internal clock phase, 0 is idle level.
    logic          mosi_q;      // Bit on the wire while ss is low.
    logic          lsb_first;
    spi_mode_e     mode;
    word_t         shift_out;   // Bits still to send, next at MSB.
    word_t         shift_in;    // Received bits, newest at LSB.
    word_t         tx_bits;     // Host word in wire order.
    logic          cpha;
    logic          cpol;
    logic          last_half;
    logic          sample_edge;
    logic          launch_edge;

    // Mirror a word so both bit orders shift MSB first.
    function automatic word_t bit_rev(input word_t w);
        word_t r;
        for (int i = 0; i < word_len; i++) begin
            r[i] = w[word_len-1-i];
        end
        return r;
    endfunction

    ////////////////////
    // Decode
    ////////////////////

    assign cpha    = mode[0];
    assign cpol    = mode[1];
    assign tx_bits = word.tx_lsb_first ? bit_rev(word.tx_word) : word.tx_word;

    // Even half periods end on the leading edge.
    assign sample_edge = half_tick && (hcnt[0] == cpha);
    assign launch_edge = half_tick && (hcnt[0] != cpha);
    assign last_half   = (hcnt == half_cnt_t'(2*word_len - 1));

    // Take only from idle, the buffer drops tx_valid on this edge.
    assign word.tx_taken = (state == idle) && word.tx_valid;
    assign word.rx_done  = (state == done);  // Done lasts one cycle.
    assign word.rx_word  = lsb_first ? bit_rev(shift_in) : shift_in;

    assign run = (state == spi_pkg::run);    // Port name hides the literal.

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            state     <= idle;
            hcnt      <= '0;
            sck_ph    <= 1'b0;
            mosi_q    <= 1'b1;
            ss        <= 1'b1;
            lsb_first <= 1'b0;
            mode      <= mode_0;     // sck idles low out of reset.
            presc     <= '0;
        end else begin
            case (state)
                idle: begin
                    if (word.tx_valid) begin
                        state     <= spi_pkg::run;
                        hcnt      <= '0;
                        ss        <= 1'b0;                     // Select the slave.
                        lsb_first <= word.tx_lsb_first;
                        mode      <= word.tx_mode;
                        presc     <= word.tx_presc;
                        // Phase 0 needs the first bit before the first edge.
                        mosi_q    <= word.tx_mode[0] ? 1'b1 : tx_bits[word_len-1];
                    end
                end
                spi_pkg::run: begin
                    if (half_tick) begin
                        sck_ph <= ~sck_ph;                     // One sck edge.
                        if (launch_edge) begin
                            mosi_q <= shift_out[word_len-1];
                        end
                        if (last_half) begin
                            state <= done;                     // sck back at idle level.
                            hcnt  <= '0;
                        end else begin
                            hcnt <= hcnt + 1'b1;
                        end
                    end
                end
                done: begin
                    state <= idle;
                    if (!word.tx_valid) begin
                        ss <= 1'b1;                            // Nothing queued, release.
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    ////////////////////
    // Shift registers
    ////////////////////

    always_ff @(posedge wr) begin
        if (word.tx_taken) begin
            // Phase 0 has already put the top bit on the wire.
            shift_out <= word.tx_mode[0] ? tx_bits : {tx_bits[word_len-2:0], 1'b1};
        end else if (launch_edge) begin
            shift_out <= {shift_out[word_len-2:0], 1'b1};   // Fill with idle ones.
        end
        if (sample_edge) begin
            shift_in <= {shift_in[word_len-2:0], miso};
        end
    end

    // Pins.
    assign sck  = sck_ph ^ cpol;
    assign mosi = ss ? 1'b1 : mosi_q;

    // A released slave sees sck at its idle level.
    a_sck_rest: assert property (@(posedge wr) disable iff (rst)
        ss |-> !sck_ph);

    // A take empties the holding buffer on the next edge.
    a_take_once: assert property (@(posedge wr) disable iff (rst)
        word.tx_taken |=> !word.tx_valid);

endmodule

`default_nettype wire

// ==== verilog/spi_word_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Word channel between the host port and the shift engine.
interface spi_word_if;
    import spi_pkg::*;

    // Transmit side, one word with its frame settings.
    logic      tx_valid;      // Holding buffer is full.
    word_t     tx_word;
    logic      tx_lsb_first;
    spi_mode_e tx_mode;
    presc_t    tx_presc;
    logic      tx_taken;      // Engine takes the word this cycle.

    // Receive side.
    logic      rx_done;       // One-cycle pulse at frame end.
    word_t     rx_word;       // Valid while rx_done is high.

    modport port (
        output tx_valid, tx_word, tx_lsb_first, tx_mode, tx_presc,
        input  tx_taken, rx_done, rx_word
    );

    modport engine (
        input  tx_valid, tx_word, tx_lsb_first, tx_mode, tx_presc,
        output tx_taken, rx_done, rx_word
    );

endinterface

`default_nettype wire
